// File: cordic_pkg.sv
package cordic_pkg;

	////////////////////////////////////////////////////////////
	// Single precision float format
	////////////////////////////////////////////////////////////

	localparam int FP_W = 32; // Whole word, sign included.
	localparam int FP_E = 8;  // Biased exponent field.
	localparam int FP_M = 23; // Stored mantissa, hidden bit not kept.

	// Field view of an IEEE-754 single. Field order matches the bit layout.
	typedef struct packed {
		logic            sign;
		logic [FP_E-1:0] exponent;
		logic [FP_M-1:0] mantissa;
	} float32_t;

	////////////////////////////////////////////////////////////
	// Start values and arctangent table
	////////////////////////////////////////////////////////////

	// X starts at the inverse CORDIC gain, about 0.6072529, so no scaling at the end.
	localparam logic [FP_W-1:0] CORDIC_X0 = 32'h3f1b74ee;
	localparam logic [FP_W-1:0] CORDIC_Y0 = 32'h00000000; // Y starts at zero.

	localparam int ITER_W = 3;            // Width of the iteration count.
	localparam int ATAN_N = 1 << ITER_W;  // Table depth, also the largest iteration count.

	// Entry i is atan(2^-i) in radians.
	// Past i = 3 the values are close to 2^-i, as expected for small angles.
	localparam logic [FP_W-1:0] ATAN_LUT [ATAN_N] = '{
		32'h3f490fdb, // 0.7853982, pi/4.
		32'h3eed6338, // 0.4636476.
		32'h3e7adbb0, // 0.2449787.
		32'h3dfeadd5, // 0.1243550.
		32'h3d7faade, // 0.0624188.
		32'h3cffeaae, // 0.0312398.
		32'h3c7ffaab, // 0.0156237.
		32'h3bfffeab  // 0.0078123.
	};

	////////////////////////////////////////////////////////////
	// Shared control and bus types
	////////////////////////////////////////////////////////////

	// Variable under update. The adder sees them in this order each iteration.
	typedef enum logic [1:0] {
		VAR_X = 2'd0,
		VAR_Y = 2'd1,
		VAR_Z = 2'd2
	} var_sel_e;

	// Command from the host, valid only in the beg_fsm_cordic cycle.
	typedef struct packed {
		float32_t   angle;     // Angle in radians, already folded into range.
		logic       operation; // 1 selects sine, 0 cosine.
		logic [1:0] region;    // Quadrant the angle was folded from.
	} cordic_cmd_t;

	// One request to the external float adder.
	typedef struct packed {
		logic [FP_W-1:0] data_a; // Variable being updated.
		logic [FP_W-1:0] data_b; // Shifted partner or table entry.
		logic            op;     // 1 subtracts data_b, 0 adds.
	} add_req_t;

	// Strobes from the control to the iteration datapath.
	typedef struct packed {
		logic              load_start; // Capture angle and start values.
		logic              sel_iter;   // Working registers take the last results.
		logic              en_work;    // Load the working registers.
		logic              en_shift;   // Load shifted X/Y, table entry and Z sign.
		var_sel_e          var_sel;    // Variable on the adder.
		logic              en_result;  // Adder result is valid, store it.
		logic [ITER_W-1:0] iter;       // Current iteration.
	} dp_ctrl_t;

	// Strobes to the output stage.
	typedef struct packed {
		logic en_select; // Pick X or Y.
		logic en_out;    // Register the signed result.
	} out_ctrl_t;

endpackage

// File: cordic_control.sv
`timescale 1ns/1ps

module cordic_control
#(
	parameter int N_ITER = 8
)
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   beg_fsm_cordic,
	input  logic                   ack_cordic,
	input  logic                   ready_add_subt,
	output logic                   ready_cordic,
	output logic                   beg_add_subt,
	output logic                   ack_add_subt,
	output cordic_pkg::dp_ctrl_t   dp_ctrl,
	output cordic_pkg::out_ctrl_t  out_ctrl
);
	import cordic_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,   // Waiting for a command.
		ST_WORK,   // Working registers load.
		ST_SHIFT,  // Shift, table and sign registers load.
		ST_REQ,    // Adder start pulse.
		ST_WAIT,   // Waiting for the adder.
		ST_SELECT, // Pick X or Y.
		ST_OUT,    // Register the result.
		ST_DONE    // Result held for the host.
	} state_e;

	state_e            state;
	state_e            state_next;
	logic [ITER_W-1:0] iter_cnt;  // Iteration in progress.
	var_sel_e          var_cnt;   // Variable in progress.
	logic              accept;    // Command taken this cycle.
	logic              res_ack;   // Adder result taken this cycle.
	logic              last_iter;
	logic              last_var;

	assign accept    = (state == ST_IDLE) && beg_fsm_cordic; // Ignored once busy.
	assign res_ack   = (state == ST_WAIT) && ready_add_subt;
	assign last_iter = (iter_cnt == ITER_W'(N_ITER - 1));
	assign last_var  = (var_cnt == VAR_Z);

	////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:   if (accept) state_next = ST_WORK;
			ST_WORK:   state_next = ST_SHIFT;
			ST_SHIFT:  state_next = ST_REQ;
			ST_REQ:    state_next = ST_WAIT;
			ST_WAIT:
			begin
				// After Z the iteration is over. Either loop or finish.
				if (res_ack)
					state_next = !last_var ? ST_REQ : (last_iter ? ST_SELECT : ST_WORK);
			end
			ST_SELECT: state_next = ST_OUT;
			ST_OUT:    state_next = ST_DONE;
			ST_DONE:   if (ack_cordic) state_next = ST_IDLE; // Host back-pressure holds here.
			default:   state_next = ST_IDLE;
		endcase
	end

	// Iteration and variable counters.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			iter_cnt <= '0;
			var_cnt  <= VAR_X;
		end
		else
		begin
			if (accept)
				iter_cnt <= '0;
			else if (res_ack && last_var && !last_iter)
				iter_cnt <= iter_cnt + 1'b1; // Next rotation.
			if (state == ST_SHIFT)
				var_cnt <= VAR_X; // Every iteration starts with X.
			else if (res_ack && !last_var)
				var_cnt <= var_sel_e'(var_cnt + 2'd1);
		end
	end

	////////////////////////////////////////////////////////////
	// Strobes
	////////////////////////////////////////////////////////////

	assign ready_cordic = (state == ST_DONE);
	assign beg_add_subt = (state == ST_REQ);
	assign ack_add_subt = res_ack; // Same cycle ready is seen.

	always_comb
	begin
		dp_ctrl.load_start = accept;
		dp_ctrl.sel_iter   = (iter_cnt != '0); // Start values only on the first pass.
		dp_ctrl.en_work    = (state == ST_WORK);
		dp_ctrl.en_shift   = (state == ST_SHIFT);
		dp_ctrl.var_sel    = var_cnt;
		dp_ctrl.en_result  = res_ack;
		dp_ctrl.iter       = iter_cnt;
		out_ctrl.en_select = (state == ST_SELECT);
		out_ctrl.en_out    = (state == ST_OUT);
	end

	// The table has ATAN_N entries, so the iteration count cannot go beyond it.
	a_n_iter_range: assert property (@(posedge clk) (N_ITER >= 1) && (N_ITER <= ATAN_N));

	// A new request never starts while the adder still shows the previous result.
	a_beg_adder_idle: assert property (@(posedge clk) disable iff (!rst_n)
		beg_add_subt |-> !ready_add_subt);

endmodule

// File: cordic_iter_datapath.sv
`timescale 1ns/1ps

module cordic_iter_datapath
(
	input  logic                         clk,
	input  logic                         rst_n,
	input  cordic_pkg::cordic_cmd_t      cmd,
	input  cordic_pkg::dp_ctrl_t         dp_ctrl,
	input  logic [cordic_pkg::FP_W-1:0]  result_add_subt,
	output cordic_pkg::add_req_t         add_req,
	output cordic_pkg::float32_t         x_result,
	output cordic_pkg::float32_t         y_result
);
	import cordic_pkg::*;

	float32_t        z_start;   // Stage 1, the command angle.
	float32_t        x_work;    // Stage 2, values for this iteration.
	float32_t        y_work;
	float32_t        z_work;
	float32_t        x_shift;   // Stage 3, X times 2^-i.
	float32_t        y_shift;   // Stage 3, Y times 2^-i.
	logic [FP_W-1:0] atan_q;    // Stage 3, atan(2^-i).
	logic            z_sign;    // Stage 3, rotation direction d.
	float32_t        z_result;  // Stage 4, last Z from the adder.

	// Multiply by 2^-count through the exponent.
	// Anything that would reach exponent zero or wrap below it becomes +0.
	function automatic float32_t shift_down(input float32_t value, input logic [ITER_W-1:0] count);
		logic [FP_E-1:0] count_ext;
		float32_t        shifted;
		count_ext = FP_E'(count);
		shifted   = value;
		if (value.exponent > count_ext)
			shifted.exponent = value.exponent - count_ext;
		else
			shifted = '0; // Also covers a zero input.
		return shifted;
	endfunction

	////////////////////////////////////////////////////////////
	// Stages 1 to 3
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (dp_ctrl.load_start)
			z_start <= cmd.angle;
	end

	// First pass takes the start values, later passes the adder results.
	always_ff @(posedge clk)
	begin
		if (dp_ctrl.en_work)
		begin
			x_work <= dp_ctrl.sel_iter ? x_result : CORDIC_X0;
			y_work <= dp_ctrl.sel_iter ? y_result : CORDIC_Y0;
			z_work <= dp_ctrl.sel_iter ? z_result : z_start;
		end
	end

	always_ff @(posedge clk)
	begin
		if (dp_ctrl.en_shift)
		begin
			x_shift <= shift_down(x_work, dp_ctrl.iter);
			y_shift <= shift_down(y_work, dp_ctrl.iter);
			atan_q  <= ATAN_LUT[dp_ctrl.iter];
			z_sign  <= z_work.sign; // 0 rotates counter-clockwise.
		end
	end

	////////////////////////////////////////////////////////////
	// Adder request
	////////////////////////////////////////////////////////////

	// With d = 0: X - Y', Y + X', Z - atan. The signs flip with d = 1.
	always_comb
	begin
		case (dp_ctrl.var_sel)
			VAR_X:
			begin
				add_req.data_a = x_work;
				add_req.data_b = y_shift;
				add_req.op     = ~z_sign;
			end
			VAR_Y:
			begin
				add_req.data_a = y_work;
				add_req.data_b = x_shift;
				add_req.op     = z_sign;
			end
			default:
			begin
				add_req.data_a = z_work;
				add_req.data_b = atan_q;
				add_req.op     = ~z_sign; // Drive Z toward zero.
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Stage 4, adder results
	////////////////////////////////////////////////////////////

	// Stage 2 still holds the operands, so writing here does not disturb the request.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			x_result <= '0;
			y_result <= '0;
			z_result <= '0;
		end
		else if (dp_ctrl.en_result)
		begin
			case (dp_ctrl.var_sel)
				VAR_X:   x_result <= result_add_subt;
				VAR_Y:   y_result <= result_add_subt;
				default: z_result <= result_add_subt;
			endcase
		end
	end

endmodule

// File: cordic_output_stage.sv
`timescale 1ns/1ps

module cordic_output_stage
(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         load_cmd,  // Command accepted.
	input  cordic_pkg::cordic_cmd_t      cmd,
	input  cordic_pkg::out_ctrl_t        out_ctrl,
	input  cordic_pkg::float32_t         x_result,  // Cosine before the sign fix.
	input  cordic_pkg::float32_t         y_result,  // Sine before the sign fix.
	output logic [cordic_pkg::FP_W-1:0]  data_output
);
	import cordic_pkg::*;

	logic       op_q;     // 1 for sine.
	logic [1:0] region_q; // Quadrant of the original angle.
	float32_t   sel_q;    // Chosen result.
	logic       negate;

	// Flags are kept for the whole command. The host may change cmd afterwards.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			op_q     <= 1'b0;
			region_q <= 2'b00;
		end
		else if (load_cmd)
		begin
			op_q     <= cmd.operation;
			region_q <= cmd.region;
		end
	end

	always_ff @(posedge clk)
	begin
		if (out_ctrl.en_select)
			sel_q <= op_q ? y_result : x_result;
	end

	// Cosine is negative in regions 01 and 10, sine in 10 and 11.
	assign negate = op_q ? region_q[1] : (region_q[1] ^ region_q[0]);

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			data_output <= '0;
		else if (out_ctrl.en_out)
			data_output <= {sel_q.sign ^ negate, sel_q.exponent, sel_q.mantissa};
	end

	// The output only takes a result that was picked in the cycle before.
	a_out_after_select: assert property (@(posedge clk) disable iff (!rst_n)
		out_ctrl.en_out |-> $past(out_ctrl.en_select));

endmodule

// File: cordic_coprocessor.sv
`timescale 1ns/1ps

module cordic_coprocessor
#(
	parameter int N_ITER = 8 // Rotations per command, 1 to 8.
)
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          beg_fsm_cordic,  // Command strobe, one cycle.
	input  logic                          ack_cordic,      // Host took data_output.
	input  cordic_pkg::cordic_cmd_t       cmd,
	input  logic                          ready_add_subt,  // Adder result is valid.
	input  logic [cordic_pkg::FP_W-1:0]   result_add_subt,
	output logic                          ready_cordic,    // Held until ack_cordic.
	output logic                          beg_add_subt,    // Adder start pulse.
	output logic                          ack_add_subt,    // Adder result taken.
	output cordic_pkg::add_req_t          add_req,
	output logic [cordic_pkg::FP_W-1:0]   data_output
);
	import cordic_pkg::*;

	dp_ctrl_t  dp_ctrl;  // Sequencing strobes for the X/Y/Z registers.
	out_ctrl_t out_ctrl; // Select and output strobes.
	float32_t  x_result; // Last X from the adder.
	float32_t  y_result; // Last Y from the adder.

	////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////

	cordic_control #(
		.N_ITER(N_ITER)
	) u_control (
		.clk            (clk),
		.rst_n          (rst_n),
		.beg_fsm_cordic (beg_fsm_cordic),
		.ack_cordic     (ack_cordic),
		.ready_add_subt (ready_add_subt),
		.ready_cordic   (ready_cordic),
		.beg_add_subt   (beg_add_subt),
		.ack_add_subt   (ack_add_subt),
		.dp_ctrl        (dp_ctrl),
		.out_ctrl       (out_ctrl)
	);

	////////////////////////////////////////////////////////////
	// Datapath and result
	////////////////////////////////////////////////////////////

	cordic_iter_datapath u_datapath (
		.clk             (clk),
		.rst_n           (rst_n),
		.cmd             (cmd),
		.dp_ctrl         (dp_ctrl),
		.result_add_subt (result_add_subt),
		.add_req         (add_req),
		.x_result        (x_result),
		.y_result        (y_result)
	);

	// The flags are taken in the same cycle as the angle.
	cordic_output_stage u_output (
		.clk         (clk),
		.rst_n       (rst_n),
		.load_cmd    (dp_ctrl.load_start),
		.cmd         (cmd),
		.out_ctrl    (out_ctrl),
		.x_result    (x_result),
		.y_result    (y_result),
		.data_output (data_output)
	);

endmodule

// File: cordic_tb_model.svh
// Reference model of the coprocessor. It is included in the body of cordic_tb.
// Floats are added in double precision and truncated back to single precision.

localparam logic [31:0] MODEL_X0 = 32'h3f1b74ee; // Inverse CORDIC gain.

// Entry i is atan(2^-i).
function automatic logic [31:0] model_atan(input int i);
	case (i)
		0:       return 32'h3f490fdb;
		1:       return 32'h3eed6338;
		2:       return 32'h3e7adbb0;
		3:       return 32'h3dfeadd5;
		4:       return 32'h3d7faade;
		5:       return 32'h3cffeaae;
		6:       return 32'h3c7ffaab;
		default: return 32'h3bfffeab;
	endcase
endfunction

// Multiplies by 2^-i. An exponent at or below i flushes the word to +0.
function automatic logic [31:0] exp_shift(input logic [31:0] v, input int i);
	int e;
	e = int'(v[30:23]);
	if (e > i)
		return {v[31], 8'(e - i), v[22:0]};
	return 32'd0;
endfunction

function automatic real f32_to_real(input logic [31:0] f);
	logic [63:0] d;
	if (f[30:23] == 8'd0)
		d = {f[31], 63'd0}; // Denormals count as zero.
	else
		d = {f[31], 11'(f[30:23]) + 11'd896, f[22:0], 29'd0}; // Rebias 127 to 1023.
	return $bitstoreal(d);
endfunction

function automatic logic [31:0] real_to_f32(input real r);
	logic [63:0] d;
	int          e;
	d = $realtobits(r);
	e = int'(d[62:52]) - 896;
	if (e <= 0)
		return 32'd0; // Zero and tiny values become +0.
	return {d[63], 8'(e), d[51:29]}; // Mantissa is truncated.
endfunction

// The op bit set means subtract.
function automatic logic [31:0] fp_add(input logic [31:0] a, input logic [31:0] b,
		input logic sub);
	real rb;
	rb = sub ? -f32_to_real(b) : f32_to_real(b);
	return real_to_f32(f32_to_real(a) + rb);
endfunction

// Fills exp_req with the adder requests of one command and sets exp_out.
task automatic run_model(input cordic_cmd_t c);
	logic [31:0] x;
	logic [31:0] y;
	logic [31:0] z;
	logic [31:0] x_sh;
	logic [31:0] y_sh;
	logic [31:0] sel;
	logic        d;
	logic        neg;
	x = MODEL_X0;
	y = 32'd0;
	z = c.angle;
	for (int i = 0; i < N_ITER; i++)
	begin
		x_sh = exp_shift(x, i);
		y_sh = exp_shift(y, i);
		d    = z[31]; // Rotation direction from the sign of Z.
		exp_req[3*i].data_a   = x;
		exp_req[3*i].data_b   = y_sh;
		exp_req[3*i].op       = !d;
		exp_req[3*i+1].data_a = y;
		exp_req[3*i+1].data_b = x_sh;
		exp_req[3*i+1].op     = d;
		exp_req[3*i+2].data_a = z;
		exp_req[3*i+2].data_b = model_atan(i);
		exp_req[3*i+2].op     = !d;
		x = fp_add(x, y_sh, !d);
		y = fp_add(y, x_sh, d); // Uses the Y of this iteration, not the new X.
		z = fp_add(z, model_atan(i), !d);
	end
	sel = c.operation ? y : x;
	if (c.operation)
		neg = (c.region == 2'b10) || (c.region == 2'b11); // Sine below the axis.
	else
		neg = (c.region == 2'b01) || (c.region == 2'b10); // Cosine left of the axis.
	exp_out = {sel[31] ^ neg, sel[30:0]};
endtask

// File: cordic_tb.sv
`timescale 1ns/1ps

module cordic_tb;
	import cordic_pkg::*;

	localparam int  N_ITER     = 8;
	localparam int  N_CMDS     = 40;
	localparam int  N_REQ      = 3 * N_ITER; // Adder requests per command.
	localparam real CLK_PERIOD = 8.0;
	localparam real DRIVE_DLY  = 1.0;        // Inputs change this long after the edge.
	localparam int  WATCHDOG_CYCLES = N_CMDS * (3 * N_ITER * 10 + 30);

	logic        clk;
	logic        rst_n;
	logic        beg_fsm_cordic;
	logic        ack_cordic;
	cordic_cmd_t cmd;
	logic        ready_add_subt;
	logic [31:0] result_add_subt;
	logic        ready_cordic;
	logic        beg_add_subt;
	logic        ack_add_subt;
	add_req_t    add_req;
	logic [31:0] data_output;

	add_req_t    exp_req [N_REQ]; // Filled by the model for each command.
	logic [31:0] exp_out;
	int          errors;
	int          checks;
	int          req_idx;        // Requests seen in the current command.
	logic        cmd_active;     // A command is between launch and ack.
	logic [31:0] cmd_seed;
	logic [31:0] add_seed;

	`include "cordic_tb_model.svh"

	cordic_coprocessor #(
		.N_ITER(N_ITER)
	) u_cordic_coprocessor (
		.clk             (clk),
		.rst_n           (rst_n),
		.beg_fsm_cordic  (beg_fsm_cordic),
		.ack_cordic      (ack_cordic),
		.cmd             (cmd),
		.ready_add_subt  (ready_add_subt),
		.result_add_subt (result_add_subt),
		.ready_cordic    (ready_cordic),
		.beg_add_subt    (beg_add_subt),
		.ack_add_subt    (ack_add_subt),
		.add_req         (add_req),
		.data_output     (data_output)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2.0) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int rand_below(input logic [31:0] state, input int n);
		return int'(state[31:16]) % n; // Upper bits are the better ones.
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	// The first eight commands walk every operation and region pair.
	task automatic make_command(input int k, output cordic_cmd_t c);
		real frac;
		cmd_seed = lcg_step(cmd_seed);
		frac     = real'(int'(cmd_seed[31:8])) / 16777216.0;
		c.angle  = real_to_f32(frac * 1.56 - 0.78); // Angle within +-0.78 rad.
		cmd_seed = lcg_step(cmd_seed);
		if (k < 8)
		begin
			c.operation = k[2];
			c.region    = k[1:0];
		end
		else
		begin
			c.operation = cmd_seed[31];
			c.region    = cmd_seed[30:29];
		end
	endtask

	////////////////////////////////////////////////////////////
	// Adder responder
	////////////////////////////////////////////////////////////

	initial
	begin
		add_req_t req;
		int       delay;
		ready_add_subt  = 1'b0;
		result_add_subt = 32'd0;
		add_seed        = 32'd29;
		forever
		begin
			@(posedge clk);
			if (rst_n && beg_add_subt)
			begin
				req = add_req;
				if (!cmd_active || req_idx >= N_REQ)
				begin
					errors++;
					$display("error at %0t: adder request outside a command or past the last one",
						$time);
				end
				else
				begin
					check_value("add_req.data_a", req.data_a, exp_req[req_idx].data_a);
					check_value("add_req.data_b", req.data_b, exp_req[req_idx].data_b);
					check_value("add_req.op", 32'(req.op), 32'(exp_req[req_idx].op));
				end
				req_idx++;
				add_seed = lcg_step(add_seed);
				delay    = rand_below(add_seed, 5); // Adder latency of 0 to 4 cycles.
				repeat (delay) @(posedge clk);
				#(DRIVE_DLY);
				ready_add_subt  = 1'b1;
				result_add_subt = fp_add(req.data_a, req.data_b, req.op);
				do
				begin
					@(posedge clk);
				end
				while (!ack_add_subt);
				if (add_req !== req)
				begin
					errors++;
					$display("error at %0t: add_req changed before ack_add_subt", $time);
				end
				#(DRIVE_DLY);
				ready_add_subt = 1'b0; // Dropped the cycle after the ack.
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Command sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		cordic_cmd_t next_cmd;
		logic [31:0] held;
		int          hold;
		errors         = 0;
		checks         = 0;
		req_idx        = 0;
		cmd_active     = 1'b0;
		cmd_seed       = 32'd29;
		rst_n          = 1'b0;
		beg_fsm_cordic = 1'b0;
		ack_cordic     = 1'b0;
		cmd            = '0;
		repeat (5) @(posedge clk);
		#(DRIVE_DLY);
		rst_n = 1'b1;
		@(posedge clk);
		check_value("ready_cordic", 32'(ready_cordic), 32'd0);
		check_value("beg_add_subt", 32'(beg_add_subt), 32'd0);
		check_value("ack_add_subt", 32'(ack_add_subt), 32'd0);
		for (int k = 0; k < N_CMDS; k++)
		begin
			make_command(k, next_cmd);
			run_model(next_cmd);
			req_idx    = 0;
			cmd_active = 1'b1;
			#(DRIVE_DLY);
			beg_fsm_cordic = 1'b1;
			cmd            = next_cmd;
			@(posedge clk);
			#(DRIVE_DLY);
			beg_fsm_cordic = 1'b0;
			cmd            = cordic_cmd_t'(~next_cmd); // The DUT must have kept its own copy.
			if (k % 2 == 1)
			begin
				// A second command while busy. It must leave no trace.
				repeat (2) @(posedge clk);
				#(DRIVE_DLY);
				beg_fsm_cordic = 1'b1;
				@(posedge clk);
				#(DRIVE_DLY);
				beg_fsm_cordic = 1'b0;
			end
			do
			begin
				@(posedge clk);
			end
			while (!ready_cordic);
			check_value("request count", 32'(req_idx), 32'(N_REQ));
			check_value("data_output magnitude", {1'b0, data_output[30:0]}, {1'b0, exp_out[30:0]});
			check_value("data_output sign", 32'(data_output[31]), 32'(exp_out[31]));
			held = data_output;
			cmd_seed = lcg_step(cmd_seed);
			hold     = rand_below(cmd_seed, 4); // Host answers after 0 to 3 cycles.
			repeat (hold)
			begin
				@(posedge clk);
				check_value("ready_cordic", 32'(ready_cordic), 32'd1);
				check_value("data_output", data_output, held);
			end
			#(DRIVE_DLY);
			ack_cordic = 1'b1;
			@(posedge clk);
			#(DRIVE_DLY);
			ack_cordic = 1'b0;
			cmd_active = 1'b0;
			@(posedge clk);
			check_value("ready_cordic", 32'(ready_cordic), 32'd0);
		end
		repeat (10) @(posedge clk); // Room for a stray request to show up.
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("error: watchdog expired after %0d cycles, the DUT stopped answering",
			WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: sim.f
+incdir+.
cordic_pkg.sv
cordic_control.sv
cordic_iter_datapath.sv
cordic_output_stage.sv
cordic_coprocessor.sv
cordic_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the CORDIC testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module cordic_tb -f sim.f -o cordic_sim
./obj_dir/cordic_sim > sim.log
cat sim.log
if grep -qF '*** PASSED ***' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
